/* project.f */
+incdir+src
+incdir+dv
src/exec_pkg.sv
src/fu_result_if.sv
src/alu_core.sv
src/alu_unit.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
dv/tb_exec_cluster.sv

/* run.sh */
#!/bin/sh
# Build and run the execution cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -Wno-fatal --top-module tb_exec_cluster -f project.f

out=$(./obj_dir/Vtb_exec_cluster)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi

/* dv/exec_ref.svh */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Expected ALU result of one issue packet, from the RV32 operand and immediate rules
function automatic exec_pkg::data_t expected_result(input exec_pkg::issue_packet_t p);
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm12;
    logic [12:0] imm13;
    logic [20:0] imm21;

    inst = p.decoded.inst;

    case (p.decoded.opa_select)
        exec_pkg::OPA_IS_RS1: a = p.rs1_value;
        exec_pkg::OPA_IS_NPC: a = p.decoded.npc;
        exec_pkg::OPA_IS_PC:  a = p.decoded.pc;
        default:              a = 32'h0;
    endcase

    // Gather each immediate field first, then extend from its top bit
    case (p.decoded.opb_select)
        exec_pkg::OPB_IS_RS2: b = p.rs2_value;
        exec_pkg::OPB_IS_I_IMM: begin
            imm12 = inst[31:20];
            b = {{20{imm12[11]}}, imm12};
        end
        exec_pkg::OPB_IS_S_IMM: begin
            imm12 = {inst[31:25], inst[11:7]};
            b = {{20{imm12[11]}}, imm12};
        end
        exec_pkg::OPB_IS_B_IMM: begin
            imm13 = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            b = {{19{imm13[12]}}, imm13};
        end
        exec_pkg::OPB_IS_U_IMM: b = {inst[31:12], 12'h000};
        exec_pkg::OPB_IS_J_IMM: begin
            imm21 = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            b = {{11{imm21[20]}}, imm21};
        end
        default: b = 32'h0;
    endcase

    case (p.decoded.alu_func)
        exec_pkg::ALU_ADD:  return a + b;
        exec_pkg::ALU_SUB:  return a - b;
        exec_pkg::ALU_AND:  return a & b;
        exec_pkg::ALU_OR:   return a | b;
        exec_pkg::ALU_XOR:  return a ^ b;
        exec_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        exec_pkg::ALU_SLL:  return a << b[4:0];     // Only five shift bits count
        exec_pkg::ALU_SRL:  return a >> b[4:0];
        exec_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
        default:            return 32'h0;
    endcase
endfunction

`endif

/* dv/tb_exec_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module tb_exec_cluster;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int STIM_CYCLES  = 2000;
    localparam int NUM_TAGS     = 1 << `TAG_WIDTH;

    typedef enum bit [1:0] {TAG_FREE, TAG_LIVE, TAG_SQUASHED} tag_state_t;

    logic                    clock = 1'b0;
    logic                    reset;
    exec_pkg::issue_packet_t issue_pack [`NUM_ALU];
    logic [`NUM_ALU-1:0]     issue_ready;
    exec_pkg::br_task_t      br_task;
    exec_pkg::b_mask_t       br_id;
    logic                    cdb_valid;
    exec_pkg::data_t         cdb_value;
    exec_pkg::tag_t          cdb_tag;

    // Scoreboard indexed by destination tag
    exec_pkg::data_t   exp_value [NUM_TAGS];
    exec_pkg::b_mask_t exp_mask [NUM_TAGS];
    tag_state_t        tag_state [NUM_TAGS];

    logic [`NUM_ALU-1:0] accepted = '0;    // Lane transferred at the last rising edge
    int                  low_run [`NUM_ALU];
    integer              seed = 32'h699a;
    int                  value_errors = 0;
    int                  protocol_errors = 0;
    int                  checked = 0;
    int                  squashed = 0;
    int                  cleared = 0;

    `include "exec_ref.svh"

    exec_cluster i_exec_cluster (
        .clock       (clock),
        .reset       (reset),
        .issue_pack  (issue_pack),
        .issue_ready (issue_ready),
        .br_task     (br_task),
        .br_id       (br_id),
        .cdb_valid   (cdb_valid),
        .cdb_value   (cdb_value),
        .cdb_tag     (cdb_tag)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                  input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic retire_result(input exec_pkg::tag_t tag, input exec_pkg::data_t value);
        if (tag_state[tag] == TAG_LIVE) begin
            compare_values(value, exp_value[tag], $sformatf("CDB value of tag %0d", tag));
            tag_state[tag] = TAG_FREE;
            checked++;
        end else if (tag_state[tag] == TAG_SQUASHED) begin
            protocol_errors++;
            $display("Tag %0d was squashed but still appeared on the CDB at %0t", tag, $time);
        end else begin
            protocol_errors++;
            $display("Tag %0d appeared on the CDB at %0t but was never issued", tag, $time);
        end
    endtask

    // Mirror of the unit branch rules
    task automatic apply_branch(input exec_pkg::br_task_t op, input exec_pkg::b_mask_t id);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (tag_state[t] == TAG_LIVE && (exp_mask[t] & id) != '0) begin
                if (op == exec_pkg::SQUASH) begin
                    tag_state[t] = TAG_SQUASHED;
                    squashed++;
                end else if (op == exec_pkg::CLEAR) begin
                    exp_mask[t] = exp_mask[t] & ~id;
                    cleared++;
                end
            end
        end
    endtask

    function automatic logic tag_in_use(input exec_pkg::tag_t tag, input int lane);
        logic busy;
        busy = (tag_state[tag] == TAG_LIVE);
        for (int j = 0; j < `NUM_ALU; j++) begin
            if (j != lane && issue_pack[j].valid && issue_pack[j].decoded.dest_tag == tag) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    function automatic int live_count();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (tag_state[t] == TAG_LIVE) n++;
        end
        return n;
    endfunction

    function automatic logic lanes_pending();
        logic any;
        any = 1'b0;
        for (int i = 0; i < `NUM_ALU; i++) begin
            any = any | issue_pack[i].valid;
        end
        return any;
    endfunction

    task automatic new_packet(input int lane);
        exec_pkg::issue_packet_t p;
        exec_pkg::tag_t          tag;
        logic [31:0]             r;
        logic [31:0]             mask_a;
        logic [31:0]             mask_b;
        do begin
            r = $random(seed);
            tag = r[`TAG_WIDTH-1:0];
        end while (tag_in_use(tag, lane));
        r = $random(seed);
        mask_a = $random(seed);
        mask_b = $random(seed);
        p.valid              = 1'b1;
        p.decoded.alu_func   = exec_pkg::alu_func_t'(4'(r % 10));
        p.decoded.opa_select = exec_pkg::opa_select_t'(r[5:4]);
        p.decoded.opb_select = exec_pkg::opb_select_t'(3'((r >> 8) % 6));
        p.decoded.dest_tag   = tag;
        p.decoded.b_mask     = exec_pkg::b_mask_t'(mask_a & mask_b);   // Sparse dependencies
        p.decoded.pc         = $random(seed) & 32'hffff_fffc;
        p.decoded.npc        = p.decoded.pc + 32'd4;
        p.decoded.inst       = $random(seed);
        p.rs1_value          = $random(seed);
        p.rs2_value          = $random(seed);
        if (r[31:29] == 3'd0) begin
            p.rs2_value = p.rs1_value;    // Equal operands for the compares
        end
        issue_pack[lane] = p;
    endtask

    task automatic drive_branch();
        logic [31:0] r;
        r = $random(seed);
        br_id = exec_pkg::b_mask_t'(1) << (r[15:8] % `BRANCH_DEPTH);
        case (r[2:0])
            3'd0:       br_task = exec_pkg::SQUASH;
            3'd1, 3'd2: br_task = exec_pkg::CLEAR;
            default:    br_task = exec_pkg::NOTHING;
        endcase
    endtask

    // Scoreboard update and result compare at every rising edge
    always @(posedge clock) begin
        exec_pkg::tag_t tag;
        if (!reset) begin
            if (cdb_valid) begin
                retire_result(cdb_tag, cdb_value);
            end
            for (int i = 0; i < `NUM_ALU; i++) begin
                accepted[i] = issue_pack[i].valid && issue_ready[i];
                if (accepted[i]) begin
                    tag = issue_pack[i].decoded.dest_tag;
                    exp_value[tag] = expected_result(issue_pack[i]);
                    exp_mask[tag]  = issue_pack[i].decoded.b_mask;
                    tag_state[tag] = TAG_LIVE;
                end
                low_run[i] = issue_ready[i] ? 0 : low_run[i] + 1;
                if (low_run[i] > `NUM_ALU) begin
                    protocol_errors++;
                    $display("Lane %0d was not ready for %0d cycles at %0t", i, low_run[i], $time);
                end
            end
            apply_branch(br_task, br_id);
        end
    end

    initial begin
        #(2 * STIM_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the cluster did not drain all issued results in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        reset   = 1'b1;
        br_task = exec_pkg::NOTHING;
        br_id   = '0;
        for (int i = 0; i < `NUM_ALU; i++) begin
            issue_pack[i] = '0;
        end

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        compare_values(32'(cdb_valid), 32'd0, "cdb_valid after reset");
        compare_values(32'(issue_ready), 32'((1 << `NUM_ALU) - 1), "issue_ready after reset");

        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(negedge clock);
            for (int i = 0; i < `NUM_ALU; i++) begin
                if (!issue_pack[i].valid || accepted[i]) begin
                    r = $random(seed);
                    if (r[2:0] != 3'd0) new_packet(i);
                    else issue_pack[i].valid = 1'b0;
                end
            end
            drive_branch();
        end

        // Stop issuing, hold pending packets until taken, then let the units drain
        while (lanes_pending() || live_count() != 0) begin
            @(negedge clock);
            br_task = exec_pkg::NOTHING;
            br_id   = '0;
            for (int i = 0; i < `NUM_ALU; i++) begin
                if (accepted[i]) issue_pack[i].valid = 1'b0;
            end
        end
        repeat (4) @(negedge clock);

        if (checked == 0) begin
            protocol_errors++;
            $display("No result was ever seen on the CDB");
        end
        if (squashed == 0) begin
            protocol_errors++;
            $display("No live entry was ever squashed by a branch");
        end
        if (cleared == 0) begin
            protocol_errors++;
            $display("No live entry ever had a branch mask bit cleared");
        end
        $display("Errors: %0d value, %0d other; checked %0d, squashed %0d, cleared %0d",
                 value_errors, protocol_errors, checked, squashed, cleared);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/exec_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_cluster (
    input  logic                    clock,
    input  logic                    reset,

    // Issue lanes
    input  exec_pkg::issue_packet_t issue_pack [`NUM_ALU],
    output logic [`NUM_ALU-1:0]     issue_ready,

    // Branch resolution broadcast
    input  exec_pkg::br_task_t      br_task,
    input  exec_pkg::b_mask_t       br_id,

    // Common data bus
    output logic                    cdb_valid,
    output exec_pkg::data_t         cdb_value,
    output exec_pkg::tag_t          cdb_tag
);

    fu_result_if fu_bus [`NUM_ALU] ();

    for (genvar i = 0; i < `NUM_ALU; i++) begin : g_lane
        alu_unit i_alu_unit (
            .clock      (clock),
            .reset      (reset),
            .issue_pack (issue_pack[i]),
            .br_task    (br_task),
            .br_id      (br_id),
            .fu         (fu_bus[i])
        );

        // A stalled unit cannot take a new packet
        assign issue_ready[i] = ~fu_bus[i].stall;
    end

    cdb_arbiter i_cdb_arbiter (
        .clock     (clock),
        .reset     (reset),
        .fu        (fu_bus),
        .cdb_valid (cdb_valid),
        .cdb_value (cdb_value),
        .cdb_tag   (cdb_tag)
    );

endmodule

`default_nettype wire

/* src/cdb_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module cdb_arbiter (
    input  logic               clock,
    input  logic               reset,
    fu_result_if.arbiter       fu [`NUM_ALU],
    output logic               cdb_valid,
    output exec_pkg::data_t    cdb_value,
    output exec_pkg::tag_t     cdb_tag
);

    localparam int IDX_W = (`NUM_ALU > 1) ? $clog2(`NUM_ALU) : 1;

    logic [`NUM_ALU-1:0] valid_vec;
    logic [`NUM_ALU-1:0] grant;
    exec_pkg::data_t     value_arr [`NUM_ALU];
    exec_pkg::tag_t      tag_arr [`NUM_ALU];
    logic [IDX_W-1:0]    ptr;          // Highest priority unit this cycle
    logic [IDX_W-1:0]    grant_idx;
    logic                found;

    for (genvar i = 0; i < `NUM_ALU; i++) begin : g_fu
        assign valid_vec[i] = fu[i].valid;
        assign value_arr[i] = fu[i].result;
        assign tag_arr[i]   = fu[i].dest_tag;
        assign fu[i].stall  = valid_vec[i] & ~grant[i];   // Lost arbitration, hold
    end

    // First valid unit at or after the pointer
    always_comb begin
        int idx;
        found     = 1'b0;
        grant_idx = '0;
        for (int k = 0; k < `NUM_ALU; k++) begin
            idx = (int'(ptr) + k) % `NUM_ALU;
            if (!found && valid_vec[idx]) begin
                found     = 1'b1;
                grant_idx = IDX_W'(idx);
            end
        end
        grant = found ? (`NUM_ALU'(1) << grant_idx) : '0;
    end

    assign cdb_valid = found;
    assign cdb_value = value_arr[grant_idx];
    assign cdb_tag   = tag_arr[grant_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (int'(grant_idx) == `NUM_ALU - 1) ? '0 : grant_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module alu_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  exec_pkg::issue_packet_t issue_pack,
    input  exec_pkg::br_task_t      br_task,
    input  exec_pkg::b_mask_t       br_id,
    fu_result_if.unit               fu
);

    exec_pkg::data_t      opa;
    exec_pkg::data_t      opb;
    exec_pkg::data_t      alu_result;
    exec_pkg::fu_packet_t held;
    exec_pkg::fu_packet_t next_entry;

    // Held entry
    logic              entry_valid;
    exec_pkg::b_mask_t entry_b_mask;
    exec_pkg::data_t   entry_result;
    exec_pkg::tag_t    entry_tag;

    alu_core i_alu_core (
        .opa      (opa),
        .opb      (opb),
        .alu_func (issue_pack.decoded.alu_func),
        .result   (alu_result)
    );

    always_comb begin
        case (issue_pack.decoded.opa_select)
            exec_pkg::OPA_IS_RS1: opa = issue_pack.rs1_value;
            exec_pkg::OPA_IS_NPC: opa = issue_pack.decoded.npc;
            exec_pkg::OPA_IS_PC:  opa = issue_pack.decoded.pc;
            default:              opa = '0;    // OPA_IS_ZERO
        endcase
    end

    always_comb begin
        case (issue_pack.decoded.opb_select)
            exec_pkg::OPB_IS_RS2:   opb = issue_pack.rs2_value;
            exec_pkg::OPB_IS_I_IMM: opb = `RV32_signext_Iimm(issue_pack.decoded.inst);
            exec_pkg::OPB_IS_S_IMM: opb = `RV32_signext_Simm(issue_pack.decoded.inst);
            exec_pkg::OPB_IS_B_IMM: opb = `RV32_signext_Bimm(issue_pack.decoded.inst);
            exec_pkg::OPB_IS_U_IMM: opb = `RV32_signext_Uimm(issue_pack.decoded.inst);
            exec_pkg::OPB_IS_J_IMM: opb = `RV32_signext_Jimm(issue_pack.decoded.inst);
            default:                opb = 32'hfeed_0b0b;
        endcase
    end

    assign held = '{
        valid:    entry_valid,
        result:   entry_result,
        dest_tag: entry_tag,
        b_mask:   entry_b_mask
    };

    always_comb begin
        next_entry = '0;    // Granted or idle, so empty unless a packet arrives
        if (fu.stall) begin
            next_entry = held;
        end else if (issue_pack.valid) begin
            next_entry = '{
                valid:    1'b1,
                result:   alu_result,
                dest_tag: issue_pack.decoded.dest_tag,
                b_mask:   issue_pack.decoded.b_mask
            };
        end

        // Branch resolution acts on whatever is about to be registered
        if ((next_entry.b_mask & br_id) != '0) begin
            if (br_task == exec_pkg::SQUASH) begin
                next_entry.valid = 1'b0;
            end else if (br_task == exec_pkg::CLEAR) begin
                next_entry.b_mask = next_entry.b_mask & ~br_id;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid  <= 1'b0;
            entry_b_mask <= '0;
        end else begin
            entry_valid  <= next_entry.valid;
            entry_b_mask <= next_entry.b_mask;
        end
    end

    always_ff @(posedge clock) begin
        entry_result <= next_entry.result;
        entry_tag    <= next_entry.dest_tag;
    end

    assign fu.valid    = entry_valid;
    assign fu.result   = entry_result;
    assign fu.dest_tag = entry_tag;
    assign fu.b_mask   = entry_b_mask;

endmodule

`default_nettype wire

/* src/alu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_core (
    input  exec_pkg::data_t     opa,
    input  exec_pkg::data_t     opb,
    input  exec_pkg::alu_func_t alu_func,
    output exec_pkg::data_t     result
);

    always_comb begin
        case (alu_func)
            exec_pkg::ALU_ADD:  result = opa + opb;
            exec_pkg::ALU_SUB:  result = opa - opb;
            exec_pkg::ALU_AND:  result = opa & opb;
            exec_pkg::ALU_OR:   result = opa | opb;
            exec_pkg::ALU_XOR:  result = opa ^ opb;
            exec_pkg::ALU_SLT: begin
                result = exec_pkg::data_t'($signed(opa) < $signed(opb));
            end
            exec_pkg::ALU_SLTU: begin
                result = exec_pkg::data_t'(opa < opb);
            end
            // Shift amount is opb[4:0] only
            exec_pkg::ALU_SLL:  result = opa << opb[4:0];
            exec_pkg::ALU_SRL:  result = opa >> opb[4:0];
            exec_pkg::ALU_SRA:  result = $signed(opa) >>> opb[4:0];   // Sign fill
            default:            result = 32'hbad0_f00d;               // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

/* src/fu_result_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Finished result of one unit on its way to the CDB arbiter
interface fu_result_if;

    logic              valid;
    exec_pkg::data_t   result;
    exec_pkg::tag_t    dest_tag;
    exec_pkg::b_mask_t b_mask;
    logic              stall;     // Not granted this cycle

    modport unit (
        output valid,
        output result,
        output dest_tag,
        output b_mask,
        input  stall
    );

    modport arbiter (
        input  valid,
        input  result,
        input  dest_tag,
        input  b_mask,
        output stall
    );

endinterface

`default_nettype wire

/* src/exec_pkg.sv */
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0]         data_t;
    typedef logic [`BRANCH_DEPTH-1:0] b_mask_t;    // One bit per unresolved branch
    typedef logic [`TAG_WIDTH-1:0]    tag_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_select_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_select_t;

    // Branch resolution broadcast
    typedef enum logic [1:0] {
        NOTHING = 2'h0,
        CLEAR   = 2'h1,    // Branch predicted correctly, drop the dependency
        SQUASH  = 2'h2     // Mispredicted, kill dependent work
    } br_task_t;

    // Decoded instruction fields needed by the ALU path
    typedef struct packed {
        data_t       pc;
        data_t       npc;
        logic [31:0] inst;
        alu_func_t   alu_func;
        opa_select_t opa_select;
        opb_select_t opb_select;
        tag_t        dest_tag;
        b_mask_t     b_mask;
    } decoded_t;

    // One issue lane's request
    typedef struct packed {
        logic     valid;
        decoded_t decoded;
        data_t    rs1_value;
        data_t    rs2_value;
    } issue_packet_t;

    // Entry held by a functional unit until it wins the bus
    typedef struct packed {
        logic    valid;
        data_t   result;
        tag_t    dest_tag;
        b_mask_t b_mask;
    } fu_packet_t;

endpackage

`default_nettype wire

/* src/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath width
`define XLEN 32

// Speculative branches in flight, one branch mask bit each
`define BRANCH_DEPTH 4

// ALU units, one per issue lane
`define NUM_ALU 2

// Destination tag is a reorder buffer index
`define TAG_WIDTH 5

// RV32 immediates, all sign-extended to 32 bits from inst[31]

// I-type: inst[31:20]
`define RV32_signext_Iimm(inst) \
    {{21{inst[31]}}, inst[30:20]}

// S-type: inst[31:25] and inst[11:7]
`define RV32_signext_Simm(inst) \
    {{21{inst[31]}}, inst[30:25], inst[11:7]}

// B-type, byte offset with bit 0 always zero
`define RV32_signext_Bimm(inst) \
    {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}

// U-type: upper 20 bits, low 12 bits zero
`define RV32_signext_Uimm(inst) \
    {inst[31:12], 12'b0}

// J-type, byte offset with bit 0 always zero
`define RV32_signext_Jimm(inst) \
    {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}

`endif
